/* verilog/fifo_pkg.sv */
package fifo_pkg;

   localparam int data_width = 8;   // payload bits per entry.
   localparam int depth      = 4;
   localparam int ptr_width  = $clog2(depth);

   typedef logic [data_width-1:0] data_t;
   typedef logic [ptr_width-1:0]  ptr_t;   // wraps modulo the depth.
   typedef data_t [depth-1:0]     mem_t;

   // fixed encodings, so a state value reads the same in every dump.
   typedef enum logic [1:0] {
      empty       = 2'b00,
      going_full  = 2'b01,
      going_empty = 2'b10,
      full        = 2'b11
   } fifo_state_t;

   typedef struct packed {
      logic  valid;
      data_t data;
   } push_req_t;

   typedef struct packed {
      logic  valid;
      data_t data;
   } pop_resp_t;

endpackage

/* verilog/fifo_write_side.sv */
`timescale 1ns/1ns

module fifo_write_side (
   input  logic                clk,
   input  logic                rst_n,
   input  fifo_pkg::push_req_t push,
   input  logic                write_ctr_en,
   input  logic                write_ctr_rst,
   output fifo_pkg::ptr_t      write_ptr,
   output fifo_pkg::mem_t      mem
);

   logic [fifo_pkg::depth-1:0] entry_we;   // one strobe per storage entry.
   fifo_pkg::ptr_t             write_ptr_inc;

   assign write_ptr_inc = write_ptr + 1'b1;   // rolls over to zero after the last entry.

   // write pointer counter.
   always_ff @(posedge clk) begin
      if (!rst_n || write_ctr_rst) begin
         write_ptr <= '0;
      end else if (write_ctr_en) begin
         write_ptr <= write_ptr_inc;
      end
   end

   // decode the granted push into a single entry strobe.
   always_comb begin
      entry_we = '0;
      if (write_ctr_en) begin
         entry_we[write_ptr] = 1'b1;
      end
   end

   // storage keeps its words across a counter reset.
   always_ff @(posedge clk) begin
      for (int i = 0; i < fifo_pkg::depth; i++) begin
         if (entry_we[i]) begin
            mem[i] <= push.data;
         end
      end
   end

endmodule

/* verilog/fifo_fsm_logic.sv */
`timescale 1ns/1ns

module fifo_fsm_logic (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           push_valid,
   input  logic           pop_ready,
   input  fifo_pkg::ptr_t read_ptr,
   input  fifo_pkg::ptr_t write_ptr,
   output logic           push_ready,
   output logic           pop_valid,
   output logic           write_ctr_en,
   output logic           read_ctr_en,
   output logic           write_ctr_rst,
   output logic           read_ctr_rst,
   output logic           err
);

   fifo_pkg::fifo_state_t state;
   fifo_pkg::fifo_state_t next_state;
   fifo_pkg::ptr_t        read_ptr_inc;
   fifo_pkg::ptr_t        write_ptr_inc;

   // the pointers after a one step advance, used to spot the last free or last used slot.
   assign read_ptr_inc  = read_ptr + 1'b1;
   assign write_ptr_inc = write_ptr + 1'b1;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= fifo_pkg::empty;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      push_ready    = 1'b0;
      pop_valid     = 1'b0;
      write_ctr_rst = 1'b0;
      read_ctr_rst  = 1'b0;
      err           = 1'b0;
      next_state    = state;
      case (state)
         fifo_pkg::empty: begin
            push_ready = 1'b1;   // nothing to pop, so only a push is granted.
            if (push_valid) begin
               next_state = fifo_pkg::going_full;
            end
         end
         fifo_pkg::going_full, fifo_pkg::going_empty: begin
            push_ready = 1'b1;
            pop_valid  = 1'b1;
            // a push with a pop keeps the occupancy, so the state holds.
            if (push_valid && !pop_ready) begin
               if (write_ptr_inc == read_ptr) begin
                  next_state = fifo_pkg::full;
               end else begin
                  next_state = fifo_pkg::going_full;
               end
            end else if (pop_ready && !push_valid) begin
               if (read_ptr_inc == write_ptr) begin
                  next_state = fifo_pkg::empty;
               end else begin
                  next_state = fifo_pkg::going_empty;
               end
            end
         end
         fifo_pkg::full: begin
            pop_valid = 1'b1;   // no room, so only a pop is granted.
            if (pop_ready) begin
               next_state = fifo_pkg::going_empty;
            end
         end
         default: begin
            // Recover from a corrupted state register by dropping the contents.
            err           = 1'b1;
            write_ctr_rst = 1'b1;
            read_ctr_rst  = 1'b1;
            next_state    = fifo_pkg::empty;
         end
      endcase
   end

   assign write_ctr_en = push_valid & push_ready;   // the granted push.
   assign read_ctr_en  = pop_ready & pop_valid;     // the granted pop.

endmodule

/* verilog/fifo_read_side.sv */
`timescale 1ns/1ns

module fifo_read_side (
   input  logic                clk,
   input  logic                rst_n,
   input  fifo_pkg::mem_t      mem,
   input  logic                pop_valid,
   input  logic                read_ctr_en,
   input  logic                read_ctr_rst,
   output fifo_pkg::ptr_t      read_ptr,
   output fifo_pkg::pop_resp_t pop
);

   fifo_pkg::ptr_t  read_ptr_inc;
   fifo_pkg::data_t head_data;

   assign read_ptr_inc = read_ptr + 1'b1;

   // read pointer counter.
   always_ff @(posedge clk) begin
      if (!rst_n || read_ctr_rst) begin
         read_ptr <= '0;
      end else if (read_ctr_en) begin
         read_ptr <= read_ptr_inc;
      end
   end

   // the oldest word sits at the read pointer.
   always_comb begin
      head_data = '0;
      for (int i = 0; i < fifo_pkg::depth; i++) begin
         if (read_ptr == fifo_pkg::ptr_t'(i)) begin
            head_data = mem[i];
         end
      end
   end

   always_comb begin
      pop.valid = pop_valid;
      pop.data  = head_data;   // only meaningful while valid is high.
   end

endmodule

/* verilog/fifo_top.sv */
`timescale 1ns/1ns

module fifo_top (
   input  logic                clk,
   input  logic                rst_n,
   input  fifo_pkg::push_req_t push,
   output logic                push_ready,
   output fifo_pkg::pop_resp_t pop,
   input  logic                pop_ready,
   output logic                err
);

   fifo_pkg::ptr_t write_ptr;
   fifo_pkg::ptr_t read_ptr;
   fifo_pkg::mem_t mem;
   logic           pop_valid;
   logic           write_ctr_en;
   logic           read_ctr_en;
   logic           write_ctr_rst;
   logic           read_ctr_rst;

   fifo_write_side u_write_side (
      .clk           (clk),
      .rst_n         (rst_n),
      .push          (push),
      .write_ctr_en  (write_ctr_en),
      .write_ctr_rst (write_ctr_rst),
      .write_ptr     (write_ptr),
      .mem           (mem)
   );

   fifo_fsm_logic u_fsm_logic (
      .clk           (clk),
      .rst_n         (rst_n),
      .push_valid    (push.valid),
      .pop_ready     (pop_ready),
      .read_ptr      (read_ptr),
      .write_ptr     (write_ptr),
      .push_ready    (push_ready),
      .pop_valid     (pop_valid),
      .write_ctr_en  (write_ctr_en),
      .read_ctr_en   (read_ctr_en),
      .write_ctr_rst (write_ctr_rst),
      .read_ctr_rst  (read_ctr_rst),
      .err           (err)
   );

   fifo_read_side u_read_side (
      .clk          (clk),
      .rst_n        (rst_n),
      .mem          (mem),
      .pop_valid    (pop_valid),
      .read_ctr_en  (read_ctr_en),
      .read_ctr_rst (read_ctr_rst),
      .read_ptr     (read_ptr),
      .pop          (pop)
   );

endmodule

/* test/fifo_asserts.sv */
`timescale 1ns/1ns

module fifo_asserts (
   input logic                clk,
   input logic                rst_n,
   input logic                push_ready,
   input fifo_pkg::pop_resp_t pop,
   input logic                pop_ready,
   input logic                err
);

   // one side can always move, since the FIFO is never both empty and full.
   property flags_never_both_low;
      @(posedge clk) disable iff (!rst_n)
         push_ready || pop.valid;
   endproperty

   property err_stays_low;
      @(posedge clk) disable iff (!rst_n)
         !err;
   endproperty

   property head_holds_under_stall;
      @(posedge clk) disable iff (!rst_n)
         (pop.valid && !pop_ready) |=> $stable(pop.data);
   endproperty

   property pop_from_full_frees_slot;
      @(posedge clk) disable iff (!rst_n)
         (!push_ready && pop_ready) |=> push_ready;   // full only refuses pushes.
   endproperty

   flags_check: assert property (flags_never_both_low)
      else $error("push_ready and pop.valid are both low");

   err_check: assert property (err_stays_low)
      else $error("err went high");

   head_check: assert property (head_holds_under_stall)
      else $error("pop.data changed while the consumer stalled");

   full_pop_check: assert property (pop_from_full_frees_slot)
      else $error("push_ready stayed low after a pop from a full FIFO");

endmodule

bind fifo_top fifo_asserts u_asserts (
   .clk        (clk),
   .rst_n      (rst_n),
   .push_ready (push_ready),
   .pop        (pop),
   .pop_ready  (pop_ready),
   .err        (err)
);

/* test/fifo_tb.sv */
`timescale 1ns/1ns

module fifo_tb;

   logic                clk;
   logic                rst_n;
   fifo_pkg::push_req_t push;
   logic                push_ready;
   fifo_pkg::pop_resp_t pop;
   logic                pop_ready;
   logic                err;

   integer              seed;
   string               test_name;
   fifo_pkg::data_t     model_q[$];   // reference contents, oldest word first.
   logic                push_taken;
   logic                pop_taken;
   fifo_pkg::data_t     taken_data;
   int                  total_pushes;
   int                  total_pops;
   int                  both_count;

   fifo_top uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (push),
      .push_ready (push_ready),
      .pop        (pop),
      .pop_ready  (pop_ready),
      .err        (err)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abort_run();
      $display("sim failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (expected == actual) else begin
         $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timed out while %s", what);
      abort_run();
   endtask

   function automatic logic chance(input int pct);
      int unsigned roll;
      roll = $unsigned($random(seed)) % 100;
      return roll < pct;
   endfunction

   // flags and head word must agree with the model after every edge.
   task automatic check_outputs();
      check_value({test_name, " pop.valid"}, 32'(model_q.size() != 0), 32'(pop.valid));
      check_value({test_name, " push_ready"}, 32'(model_q.size() < fifo_pkg::depth),
                  32'(push_ready));
      check_value({test_name, " err"}, 32'(0), 32'(err));
      if (model_q.size() != 0) begin
         check_value({test_name, " pop.data"}, 32'(model_q[0]), 32'(pop.data));
      end
   endtask

   // the handshakes seen before this edge take effect at it.
   task automatic apply_handshake();
      if (pop_taken) begin
         void'(model_q.pop_front());
         total_pops++;
      end
      if (push_taken) begin
         model_q.push_back(taken_data);
         total_pushes++;
      end
      if (push_taken && pop_taken) begin
         both_count++;
      end
   endtask

   task automatic run_cycle(input logic push_v, input fifo_pkg::data_t push_d,
                            input logic pop_r);
      @(posedge clk);
      apply_handshake();
      push.valid <= push_v;
      push.data  <= push_d;
      pop_ready  <= pop_r;
      @(negedge clk);   // outputs are settled here.
      check_outputs();
      push_taken = push.valid && push_ready;
      pop_taken  = pop.valid && pop_ready;
      taken_data = push.data;
   endtask

   task automatic drain(input string name);
      int waited;
      int pops_before;
      int expected;
      test_name = name;
      run_cycle(1'b0, '0, 1'b0);   // lets any pending handshake settle.
      expected    = model_q.size();
      pops_before = total_pops;
      waited      = 0;
      while (pop.valid) begin
         run_cycle(1'b0, '0, 1'b1);
         waited++;
         if (waited > fifo_pkg::depth + 2) begin
            report_timeout("draining the FIFO");
         end
      end
      check_value({name, " words drained"}, 32'(expected), 32'(total_pops - pops_before));
      check_value({name, " model count"}, 32'(0), 32'(model_q.size()));
   endtask

   task automatic run_backpressure();
      int waited;
      int pushes_before;
      test_name     = "backpressure";
      pushes_before = total_pushes;
      waited        = 0;
      while (push_ready) begin
         run_cycle(1'b1, fifo_pkg::data_t'($random(seed)), 1'b0);
         waited++;
         if (waited > fifo_pkg::depth + 2) begin
            report_timeout("filling the FIFO under back-pressure");
         end
      end
      check_value("backpressure accepted", 32'(fifo_pkg::depth),
                  32'(total_pushes - pushes_before));
      repeat (6) run_cycle(1'b1, fifo_pkg::data_t'($random(seed)), 1'b0);
      check_value("backpressure model count", 32'(fifo_pkg::depth), 32'(model_q.size()));
      drain("backpressure drain");
   endtask

   task automatic run_simultaneous();
      test_name = "simultaneous";
      run_cycle(1'b1, fifo_pkg::data_t'($random(seed)), 1'b0);
      run_cycle(1'b1, fifo_pkg::data_t'($random(seed)), 1'b0);
      repeat (16) run_cycle(1'b1, fifo_pkg::data_t'($random(seed)), 1'b1);
      check_value("simultaneous model count", 32'(2), 32'(model_q.size()));
      drain("simultaneous drain");
   endtask

   task automatic run_random_phase(input string name, input int push_pct,
                                   input int pop_pct, input int cycles);
      test_name = name;
      for (int i = 0; i < cycles; i++) begin
         run_cycle(chance(push_pct), fifo_pkg::data_t'($random(seed)), chance(pop_pct));
      end
   endtask

   initial begin
      seed         = 32'hce1aefea;
      rst_n        <= 1'b0;
      push         <= '0;
      pop_ready    <= 1'b0;
      push_taken   = 1'b0;
      pop_taken    = 1'b0;
      taken_data   = '0;
      total_pushes = 0;
      total_pops   = 0;
      both_count   = 0;
      test_name    = "reset";

      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("reset pop.valid", 32'(0), 32'(pop.valid));
      check_value("reset push_ready", 32'(1), 32'(push_ready));
      check_value("reset err", 32'(0), 32'(err));

      run_backpressure();
      run_simultaneous();

      run_random_phase("random balanced", 50, 50, 400);
      run_random_phase("random filling", 80, 20, 300);
      run_random_phase("random emptying", 20, 80, 300);
      run_random_phase("random streaming", 100, 100, 200);
      run_random_phase("random busy", 90, 90, 200);
      drain("final drain");

      assert (both_count > 0) else begin
         $display("no cycle had a push and a pop accepted together");
         abort_run();
      end

      $display("sim passed");
      $finish;
   end

endmodule

/* all.f */
verilog/fifo_pkg.sv
verilog/fifo_write_side.sv
verilog/fifo_fsm_logic.sv
verilog/fifo_read_side.sv
verilog/fifo_top.sv
test/fifo_asserts.sv
test/fifo_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the FIFO testbench with Verilator.
set -e

cd "$(dirname "$0")"

log_file=sim.log

verilator --binary --timing --assert \
   -f all.f \
   --top-module fifo_tb \
   -o fifo_sim

./obj_dir/fifo_sim 2>&1 | tee "$log_file"

if grep -q "^sim passed$" "$log_file"; then
   echo "result: PASS"
else
   echo "result: FAIL"
   exit 1
fi
